//--- verilog/cpu_pkg.sv
package cpu_pkg;

    // Supported opcodes
    localparam logic [7:0] OP_LDA_ZPG = 8'hA5;
    localparam logic [7:0] OP_STA_ZPG = 8'h85;
    localparam logic [7:0] OP_ASL_ZPG = 8'h06;
    localparam logic [7:0] OP_LSR_ZPG = 8'h46;
    localparam logic [7:0] OP_NOP     = 8'hEA;

    localparam logic [2:0] ADR_ZPG = 3'b001;  // bbb field for zero page

    // ALU operations
    localparam logic [1:0] ALU_PASS = 2'd0;
    localparam logic [1:0] ALU_ASL  = 2'd1;
    localparam logic [1:0] ALU_LSR  = 2'd2;

    // Input latch and data buffer controls
    localparam logic [1:0] BUF_IDLE  = 2'd0;
    localparam logic [1:0] BUF_LOAD  = 2'd1;
    localparam logic [1:0] BUF_STORE = 2'd2;

    // Status word layout, V and I style bits are not implemented
    localparam int STATUS_W = 7;
    localparam int FLAG_C   = 0;
    localparam int FLAG_Z   = 1;
    localparam int FLAG_N   = 6;

    localparam logic [15:0] RESET_PC_DEFAULT = 16'h0200;

    // One opcode byte seen as raw value or as aaa/bbb/cc fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;
            logic [2:0] bbb;  // Addressing mode
            logic [1:0] cc;
        } f;
    } opcode_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [1:0] alu_op,
    input  logic [7:0] operand,
    input  logic       carry_in,
    output logic [7:0] result,
    output logic [cpu_pkg::STATUS_W-1:0] flags
);
    import cpu_pkg::*;

    logic carry_out;

    always_comb begin
        case (alu_op)
            ALU_ASL: begin
                result    = {operand[6:0], 1'b0};
                carry_out = operand[7];
            end
            ALU_LSR: begin
                result    = {1'b0, operand[7:1]};  // N ends up clear
                carry_out = operand[0];
            end
            default: begin
                result    = operand;   // Load path
                carry_out = carry_in;
            end
        endcase
    end

    always_comb begin
        flags         = '0;
        flags[FLAG_C] = carry_out;
        flags[FLAG_Z] = (result == 8'h00);
        flags[FLAG_N] = result[7];
    end

endmodule

//--- verilog/address_unit.sv
`timescale 1ns/1ps

module address_unit #(
    parameter logic [15:0] RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic        pc_enable,
    input  logic        operand_load,
    input  logic        address_select,
    input  logic [7:0]  data_in,
    output logic [15:0] address
);

    logic [15:0] pc;
    logic [7:0]  operand;  // Zero-page address byte

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (rdy && pc_enable) begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && operand_load) begin
            operand <= data_in;
        end
    end

    // Page zero when the operand drives the bus
    assign address = address_select ? {8'h00, operand} : pc;

endmodule

//--- verilog/data_path.sv
`timescale 1ns/1ps

module data_path (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rdy,
    input  logic [7:0] data_in,
    input  logic [1:0] idl_ctl,
    input  logic [1:0] dbuf_ctl,
    input  logic       acc_load,
    input  logic       status_load,
    input  logic [cpu_pkg::STATUS_W-1:0] status_mask,
    input  logic [7:0] alu_result,
    input  logic [cpu_pkg::STATUS_W-1:0] alu_flags,
    output logic [7:0] alu_operand,
    output logic [7:0] data_out,
    output logic [7:0] accumulator,
    output logic [cpu_pkg::STATUS_W-1:0] status
);
    import cpu_pkg::*;

    logic [7:0] idl_q;   // Input data latch
    logic [7:0] dbuf_q;  // Data output buffer

    // Shifts read the latch, loads see the bus directly
    assign alu_operand = (idl_ctl == BUF_STORE) ? idl_q : data_in;

    assign data_out = (dbuf_ctl == BUF_STORE) ? dbuf_q : 8'h00;

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (idl_ctl == BUF_LOAD) begin
                idl_q <= data_in;
            end
            if (dbuf_ctl == BUF_LOAD) begin
                // A shift is under way when the latch drives the ALU
                dbuf_q <= (idl_ctl == BUF_STORE) ? alu_result : accumulator;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            accumulator <= 8'h00;
            status      <= '0;
        end else if (rdy) begin
            if (acc_load) begin
                accumulator <= alu_result;
            end
            if (status_load) begin
                status <= (status & ~status_mask) | (alu_flags & status_mask);  // Masked bits only
            end
        end
    end

endmodule

//--- verilog/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             rdy,
    input  cpu_pkg::opcode_t data_in,
    output logic             pc_enable,
    output logic             operand_load,
    output logic             address_select,
    output logic             rw,              // 1 read, 0 write
    output logic [1:0]       alu_op,
    output logic [1:0]       idl_ctl,
    output logic [1:0]       dbuf_ctl,
    output logic             acc_load,
    output logic             status_load,
    output logic [cpu_pkg::STATUS_W-1:0] status_mask
);
    import cpu_pkg::*;

    localparam logic [2:0] S_IDLE         = 3'd0;
    localparam logic [2:0] S_OPCODE_READ  = 3'd1;
    localparam logic [2:0] S_ZPG_ADR_READ = 3'd2;
    localparam logic [2:0] S_IDL_WRITE    = 3'd3;
    localparam logic [2:0] S_ALU_ZPG      = 3'd4;
    localparam logic [2:0] S_DBUF_OUTPUT  = 3'd5;

    logic [2:0] state;
    logic [2:0] next_state;
    opcode_t    opcode_q;
    logic [2:0] adr_mode_q;
    logic       supported;

    // Anything outside this set runs as a NOP
    assign supported = (data_in.raw == OP_LDA_ZPG) || (data_in.raw == OP_STA_ZPG) ||
                       (data_in.raw == OP_ASL_ZPG) || (data_in.raw == OP_LSR_ZPG);

    always_comb begin
        next_state     = state;
        pc_enable      = 1'b0;
        operand_load   = 1'b0;
        address_select = 1'b0;
        rw             = 1'b1;
        alu_op         = ALU_PASS;
        idl_ctl        = BUF_IDLE;
        dbuf_ctl       = BUF_IDLE;
        acc_load       = 1'b0;
        status_load    = 1'b0;
        status_mask    = '0;

        case (state)
            S_IDLE: begin
                next_state = S_OPCODE_READ;  // Also the dummy cycle of NOP
            end
            S_OPCODE_READ: begin
                pc_enable = 1'b1;
                if (supported && data_in.f.bbb == ADR_ZPG) begin
                    next_state = S_ZPG_ADR_READ;
                end else begin
                    next_state = S_IDLE;
                end
            end
            S_ZPG_ADR_READ: begin
                pc_enable    = 1'b1;  // Step past the operand byte
                operand_load = 1'b1;
                next_state   = S_OPCODE_READ;
                if (adr_mode_q == ADR_ZPG) begin
                    case (opcode_q.raw)
                        OP_STA_ZPG: begin
                            dbuf_ctl   = BUF_LOAD;  // Buffer takes the accumulator
                            next_state = S_DBUF_OUTPUT;
                        end
                        OP_LDA_ZPG, OP_ASL_ZPG, OP_LSR_ZPG: begin
                            next_state = S_IDL_WRITE;
                        end
                        default: begin
                            next_state = S_OPCODE_READ;
                        end
                    endcase
                end
            end
            S_IDL_WRITE: begin
                address_select = 1'b1;
                idl_ctl        = BUF_LOAD;
                if (opcode_q.raw == OP_LDA_ZPG) begin
                    // Memory byte goes straight through the ALU into A
                    acc_load            = 1'b1;
                    status_load         = 1'b1;
                    status_mask[FLAG_N] = 1'b1;
                    status_mask[FLAG_Z] = 1'b1;
                    next_state          = S_OPCODE_READ;
                end else begin
                    next_state = S_ALU_ZPG;
                end
            end
            S_ALU_ZPG: begin
                address_select      = 1'b1;
                idl_ctl             = BUF_STORE;  // Latch feeds the shifter
                dbuf_ctl            = BUF_LOAD;
                alu_op              = (opcode_q.raw == OP_LSR_ZPG) ? ALU_LSR : ALU_ASL;
                status_load         = 1'b1;
                status_mask[FLAG_N] = 1'b1;
                status_mask[FLAG_Z] = 1'b1;
                status_mask[FLAG_C] = 1'b1;
                next_state          = S_DBUF_OUTPUT;
            end
            S_DBUF_OUTPUT: begin
                address_select = 1'b1;
                rw             = 1'b0;
                dbuf_ctl       = BUF_STORE;
                next_state     = S_OPCODE_READ;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            opcode_q   <= OP_NOP;
            adr_mode_q <= 3'b000;
        end else if (rdy) begin
            state <= next_state;
            if (state == S_OPCODE_READ) begin
                opcode_q   <= data_in;
                adr_mode_q <= data_in.f.bbb;
            end
        end
    end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [15:0] RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic [7:0]  data_in,
    output logic [15:0] address,
    output logic [7:0]  data_out,
    output logic        rw,
    output logic [7:0]  accumulator,
    output logic [cpu_pkg::STATUS_W-1:0] status
);
    import cpu_pkg::*;

    opcode_t               fetch_word;
    logic                  pc_enable;
    logic                  operand_load;
    logic                  address_select;
    logic [1:0]            alu_op;
    logic [1:0]            idl_ctl;
    logic [1:0]            dbuf_ctl;
    logic                  acc_load;
    logic                  status_load;
    logic [STATUS_W-1:0]   status_mask;
    logic [7:0]            alu_operand;
    logic [7:0]            alu_result;
    logic [STATUS_W-1:0]   alu_flags;

    assign fetch_word.raw = data_in;

    instruction_decode decode_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .rdy            (rdy),
        .data_in        (fetch_word),
        .pc_enable      (pc_enable),
        .operand_load   (operand_load),
        .address_select (address_select),
        .rw             (rw),
        .alu_op         (alu_op),
        .idl_ctl        (idl_ctl),
        .dbuf_ctl       (dbuf_ctl),
        .acc_load       (acc_load),
        .status_load    (status_load),
        .status_mask    (status_mask)
    );

    address_unit #(
        .RESET_PC (RESET_PC)
    ) address_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .rdy            (rdy),
        .pc_enable      (pc_enable),
        .operand_load   (operand_load),
        .address_select (address_select),
        .data_in        (data_in),
        .address        (address)
    );

    data_path data_path_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .data_in     (data_in),
        .idl_ctl     (idl_ctl),
        .dbuf_ctl    (dbuf_ctl),
        .acc_load    (acc_load),
        .status_load (status_load),
        .status_mask (status_mask),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .alu_operand (alu_operand),
        .data_out    (data_out),
        .accumulator (accumulator),
        .status      (status)
    );

    alu alu_inst (
        .alu_op   (alu_op),
        .operand  (alu_operand),
        .carry_in (status[FLAG_C]),  // Held carry for the pass operation
        .result   (alu_result),
        .flags    (alu_flags)
    );

endmodule

//--- verification/bus_monitor.sv
`timescale 1ns/1ps

module bus_monitor #(
    parameter int ROWS = 12
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic        fetch,
    input  logic [15:0] address,
    input  logic [7:0]  data_out,
    input  logic        rw,
    input  logic [7:0]  accumulator,
    input  logic [cpu_pkg::STATUS_W-1:0] status,
    output logic [31:0] errors,
    output logic        done
);
    import cpu_pkg::*;

    int          cur    = -1;  // Row of the instruction in progress
    logic [15:0] exp_pc = 16'h0300;
    logic        wrote  = 1'b0;

    initial begin
        errors = 0;
        done   = 1'b0;
    end

    // Sampled mid-cycle where bus and registers are settled
    always @(negedge clk) begin
        if (!arst_n) begin
            if (!rw) begin
                $display("Write strobe seen while reset is asserted");
                errors = errors + 1;
            end
        end else if (rdy && !done) begin
            if (fetch) begin
                if (cur >= 0) begin
                    if (accumulator !== cpu_core_tb.row_acc[cur]) begin
                        $display("[FAIL] %s accumulator expected %h actual %h",
                                 cpu_core_tb.test_name[cur], cpu_core_tb.row_acc[cur],
                                 accumulator);
                        errors = errors + 1;
                    end
                    if (status !== cpu_core_tb.row_status[cur]) begin
                        $display("[FAIL] %s status expected %h actual %h",
                                 cpu_core_tb.test_name[cur], cpu_core_tb.row_status[cur],
                                 status);
                        errors = errors + 1;
                    end
                    if (cpu_core_tb.row_has_write[cur] && !wrote) begin
                        $display("Instruction %s finished without its memory write",
                                 cpu_core_tb.test_name[cur]);
                        errors = errors + 1;
                    end
                end
                if (cur + 1 < ROWS) begin
                    if (address !== exp_pc) begin
                        $display("[FAIL] %s fetch address expected %h actual %h",
                                 cpu_core_tb.test_name[cur + 1], exp_pc, address);
                        errors = errors + 1;
                    end
                    exp_pc <= exp_pc +
                              ((cpu_core_tb.row_opcode[cur + 1] == OP_NOP) ? 16'd1 : 16'd2);
                end
                if (cur + 1 >= ROWS - 1) begin
                    done <= 1'b1;  // Final NOP reached
                end
                cur   <= cur + 1;
                wrote <= 1'b0;
            end else if (!rw) begin
                wrote <= 1'b1;
                if (cur < 0 || !cpu_core_tb.row_has_write[cur]) begin
                    $display("Unexpected memory write at address %h", address);
                    errors = errors + 1;
                end else if (address !== {8'h00, cpu_core_tb.row_zp[cur]} ||
                             data_out !== cpu_core_tb.row_wdata[cur]) begin
                    $display("[FAIL] %s write expected %h=%h actual %h=%h",
                             cpu_core_tb.test_name[cur], {8'h00, cpu_core_tb.row_zp[cur]},
                             cpu_core_tb.row_wdata[cur], address, data_out);
                    errors = errors + 1;
                end
            end
        end
    end

endmodule

//--- verification/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int ROWS = 12;

    logic                clk    = 1'b0;
    logic                arst_n = 1'b0;
    logic                rdy    = 1'b0;
    logic [7:0]          data_in;
    logic [15:0]         address;
    logic [7:0]          data_out;
    logic                rw;
    logic [7:0]          accumulator;
    logic [STATUS_W-1:0] status;

    logic [7:0]          mem [0:65535];
    string               test_name   [ROWS];
    logic [7:0]          row_opcode  [ROWS];
    logic [7:0]          row_zp      [ROWS];
    logic [7:0]          row_preload [ROWS];
    logic                row_has_write [ROWS];
    logic [7:0]          row_wdata   [ROWS];
    logic [7:0]          row_acc     [ROWS];
    logic [STATUS_W-1:0] row_status  [ROWS];

    integer      seed = 32'h436c;
    int          fill_idx;
    int          row;
    int          cycles;
    int          timeout_errors = 0;
    logic [15:0] pc;
    logic        fetch;
    logic [31:0] check_errors;
    logic        done;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        rdy <= ($random(seed) & 3) != 0;  // Stalls about one cycle in four
    end

    // Memory answers in the same cycle, writes land on completed cycles
    assign data_in = mem[address];

    always @(posedge clk) begin
        if (arst_n && rdy && !rw) begin
            mem[address] <= data_out;
        end
    end

    // Decoder state 1 is the opcode fetch cycle
    assign fetch = (cpu_core_inst.decode_inst.state == 3'd1);

    cpu_core #(
        .RESET_PC (16'h0300)
    ) cpu_core_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .data_in     (data_in),
        .address     (address),
        .data_out    (data_out),
        .rw          (rw),
        .accumulator (accumulator),
        .status      (status)
    );

    bus_monitor #(
        .ROWS (ROWS)
    ) bus_monitor_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rdy         (rdy),
        .fetch       (fetch),
        .address     (address),
        .data_out    (data_out),
        .rw          (rw),
        .accumulator (accumulator),
        .status      (status),
        .errors      (check_errors),
        .done        (done)
    );

    task automatic add_row(input int idx, input string name, input logic [7:0] op,
                           input logic [7:0] zp, input logic [7:0] pre, input logic has_w,
                           input logic [7:0] wdata, input logic [7:0] acc,
                           input logic n, input logic z, input logic c);
        test_name[idx]     = name;
        row_opcode[idx]    = op;
        row_zp[idx]        = zp;
        row_preload[idx]   = pre;
        row_has_write[idx] = has_w;
        row_wdata[idx]     = wdata;
        row_acc[idx]       = acc;
        row_status[idx]         = '0;
        row_status[idx][FLAG_N] = n;
        row_status[idx][FLAG_Z] = z;
        row_status[idx][FLAG_C] = c;
    endtask

    initial begin
        for (fill_idx = 0; fill_idx < 65536; fill_idx++) begin
            mem[fill_idx] = fill_idx[7:0] ^ fill_idx[15:8] ^ 8'h5A;
        end

        //      name          opcode      zp     pre    wr    wdata  acc    N  Z  C
        add_row(0,  "lda_neg",  OP_LDA_ZPG, 8'h10, 8'h80, 1'b0, 8'h00, 8'h80, 1, 0, 0);
        add_row(1,  "asl_c",    OP_ASL_ZPG, 8'h11, 8'h81, 1'b1, 8'h02, 8'h80, 0, 0, 1);
        add_row(2,  "lsr_zero", OP_LSR_ZPG, 8'h12, 8'h01, 1'b1, 8'h00, 8'h80, 0, 1, 1);
        add_row(3,  "lda_zero", OP_LDA_ZPG, 8'h13, 8'h00, 1'b0, 8'h00, 8'h00, 0, 1, 1);
        add_row(4,  "nop",      OP_NOP,     8'h00, 8'h00, 1'b0, 8'h00, 8'h00, 0, 1, 1);
        add_row(5,  "lda_pos",  OP_LDA_ZPG, 8'h14, 8'h7E, 1'b0, 8'h00, 8'h7E, 0, 0, 1);
        add_row(6,  "sta",      OP_STA_ZPG, 8'h15, 8'h33, 1'b1, 8'h7E, 8'h7E, 0, 0, 1);
        add_row(7,  "asl_neg",  OP_ASL_ZPG, 8'h16, 8'h40, 1'b1, 8'h80, 8'h7E, 1, 0, 0);
        add_row(8,  "lsr_b7",   OP_LSR_ZPG, 8'h17, 8'h80, 1'b1, 8'h40, 8'h7E, 0, 0, 0);
        add_row(9,  "asl_zero", OP_ASL_ZPG, 8'h18, 8'h00, 1'b1, 8'h00, 8'h7E, 0, 1, 0);
        add_row(10, "lsr_c",    OP_LSR_ZPG, 8'h19, 8'h03, 1'b1, 8'h01, 8'h7E, 0, 0, 1);
        add_row(11, "nop_end",  OP_NOP,     8'h00, 8'h00, 1'b0, 8'h00, 8'h7E, 0, 0, 1);

        pc = 16'h0300;
        for (row = 0; row < ROWS; row++) begin
            mem[pc] = row_opcode[row];
            if (row_opcode[row] == OP_NOP) begin
                pc = pc + 16'd1;
            end else begin
                mem[pc + 16'd1]       = row_zp[row];
                mem[{8'h00, row_zp[row]}] = row_preload[row];
                pc = pc + 16'd2;
            end
        end

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        cycles = 0;
        while (!done && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: the final NOP fetch never came");
            timeout_errors++;
        end

        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/address_unit.sv
verilog/data_path.sv
verilog/instruction_decode.sv
verilog/cpu_core.sv
verification/bus_monitor.sv
verification/cpu_core_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the cpu_core testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module cpu_core_tb -Mdir obj_dir -f verilog.f
	./obj_dir/Vcpu_core_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
